// File: sim/rename_patterns.txt
# v1 k1 rd1 rs1 rs2  v2 k2 rd2 rs1 rs2  rdy full two flush fid  cv cf cl cpdst cppdst
# then vo1 pdst psrc1 psrc2 ppdst  vo2 pdst psrc1 psrc2 ppdst; kind 0 alu 1 load 2 store 3 branch
1 0 5 6 7  0 0 0 0 0  1 0 1 0 0  0 0 0 0 0  1 32 6 7 5  0 0 0 0 0
1 0 3 5 1  1 0 3 3 2  1 0 1 0 0  0 0 0 0 0  1 33 32 1 3  1 34 33 2 33
1 0 0 1 2  1 2 4 5 3  1 0 1 0 0  0 0 0 0 0  1 0 1 2 0  1 4 32 34 4
1 0 6 3 0  0 0 0 0 0  1 0 1 0 0  0 0 0 0 0  1 35 34 0 6  0 0 0 0 0
1 0 7 6 6  0 0 0 0 0  0 0 1 0 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0
1 0 7 6 6  0 0 0 0 0  1 1 1 0 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0
1 0 7 6 6  1 0 8 7 1  1 0 0 0 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0
1 0 7 6 6  1 0 8 7 1  1 0 1 0 0  0 0 0 0 0  1 36 35 35 7  1 37 36 1 8
1 3 0 7 8  1 0 9 7 8  1 0 1 0 0  0 0 0 0 0  1 0 36 37 0  1 38 36 37 9
1 0 7 9 0  0 0 0 0 0  1 0 1 0 0  0 0 0 0 0  1 39 38 0 36  0 0 0 0 0
1 0 8 7 9  0 0 0 0 0  1 0 1 1 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0
1 0 8 7 9  0 0 0 0 0  1 0 1 0 0  0 0 0 0 0  1 40 36 38 37  0 0 0 0 0
1 0 10 0 0  1 0 11 0 0  1 0 1 0 0  0 0 0 0 0  1 41 0 0 10  1 42 0 0 11
1 0 12 0 0  1 0 13 0 0  1 0 1 0 0  0 0 0 0 0  1 43 0 0 12  1 44 0 0 13
1 0 14 0 0  1 0 15 0 0  1 0 1 0 0  0 0 0 0 0  1 45 0 0 14  1 46 0 0 15
1 0 16 0 0  1 0 17 0 0  1 0 1 0 0  0 0 0 0 0  1 47 0 0 16  1 48 0 0 17
1 0 18 0 0  1 0 19 0 0  1 0 1 0 0  0 0 0 0 0  1 49 0 0 18  1 50 0 0 19
1 0 20 0 0  1 0 21 0 0  1 0 1 0 0  0 0 0 0 0  1 51 0 0 20  1 52 0 0 21
1 0 22 0 0  1 0 23 0 0  1 0 1 0 0  0 0 0 0 0  1 53 0 0 22  1 54 0 0 23
1 0 24 0 0  1 0 25 0 0  1 0 1 0 0  0 0 0 0 0  1 55 0 0 24  1 56 0 0 25
1 0 26 0 0  1 0 27 0 0  1 0 1 0 0  0 0 0 0 0  1 57 0 0 26  1 58 0 0 27
1 0 28 0 0  1 0 29 0 0  1 0 1 0 0  0 0 0 0 0  1 59 0 0 28  1 60 0 0 29
1 0 30 0 0  1 0 31 0 0  1 0 1 0 0  0 0 0 0 0  1 61 0 0 30  1 62 0 0 31
1 0 1 0 0  0 0 0 0 0  1 0 1 0 0  0 0 0 0 0  1 63 0 0 1  0 0 0 0 0
1 0 2 0 0  0 0 0 0 0  1 0 1 0 0  1 0 5 32 5  0 0 0 0 0  0 0 0 0 0
1 0 2 0 0  0 0 0 0 0  1 0 1 0 0  1 1 6 35 6  1 5 0 0 2  0 0 0 0 0
1 0 4 2 0  0 0 0 0 0  1 0 1 0 0  0 0 0 0 0  1 35 5 0 4  0 0 0 0 0
1 0 4 2 0  0 0 0 0 0  1 0 1 0 0  0 0 0 0 0  0 0 0 0 0  0 0 0 0 0

// File: filelist.f
+incdir+verilog
verilog/rename_pkg.sv
verilog/rename_ifs.sv
verilog/free_list.sv
verilog/rat.sv
verilog/rename_ctrl.sv
verilog/rename_stage.sv
sim/rename_chk.sv
sim/rename_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= rename_tb
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG) || ! grep -q "=== PASS ===" $(LOG); then \
		echo "Simulation did not pass, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/rename_tb.sv
`include "rename_settings.svh"

module rename_tb;
    import rename_pkg::*;

    // Stimulus plus expected columns on each pattern line
    localparam int NCOL      = 30;
    localparam int MAX_LINES = 4 * `FL_DEPTH;

    logic        clk, arst_n;
    logic        valid_i_1, valid_i_2;
    instr_kind_e kind_1, kind_2;
    lreg_t       rd_1, rs1_1, rs2_1;
    lreg_t       rd_2, rs1_2, rs2_2;
    logic        ready_i, rob_full, rob_two_empty;
    logic        flush_valid;
    ckpt_id_t    flush_rat_id;
    logic        commit_valid_1, commit_flushed_1;
    lreg_t       commit_ldst_1;
    preg_t       commit_pdst_1, commit_ppdst_1;
    logic        commit_valid_2, commit_flushed_2;
    lreg_t       commit_ldst_2;
    preg_t       commit_pdst_2, commit_ppdst_2;
    logic        valid_o_1, valid_o_2, ready_o;
    preg_t       pdst_1, psrc1_1, psrc2_1, ppdst_1;
    preg_t       pdst_2, psrc1_2, psrc2_2, ppdst_2;
    ckpt_id_t    rat_id_1, rat_id_2;

    int want [10];
    int line_no;
    int n_checks;
    int n_errors;
    int n_assert;

    // Checkpoint id the RAT holds in the current cycle
    ckpt_id_t exp_id;

    rename_stage uut (.*);

    bind rename_ctrl rename_chk u_chk (
        .clk     (rename_tb.clk),
        .arst_n  (rename_tb.arst_n),
        .pop_cnt (alloc.pop_cnt),
        .has_1   (alloc.has_1),
        .has_2   (alloc.has_2),
        .*
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Drives one pattern line onto the DUT inputs and loads its expected columns
    task automatic load_line(input string s, output int n);
        int k1;
        int k2;
        n = $sscanf(s, "%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d%d",
            valid_i_1, k1, rd_1, rs1_1, rs2_1,
            valid_i_2, k2, rd_2, rs1_2, rs2_2,
            ready_i, rob_full, rob_two_empty, flush_valid, flush_rat_id,
            commit_valid_1, commit_flushed_1, commit_ldst_1, commit_pdst_1, commit_ppdst_1,
            want[0], want[1], want[2], want[3], want[4],
            want[5], want[6], want[7], want[8], want[9]);
        kind_1 = instr_kind_e'(k1);
        kind_2 = instr_kind_e'(k2);
    endtask

    task automatic check_val(input string name, input int got, input int want_val);
        n_checks++;
        if (got != want_val) begin
            n_errors++;
            $display("Error at %0t: pattern line %0d, %s is %0d, expected %0d",
                $time, line_no, name, got, want_val);
        end
    endtask

    // Renamed fields only matter when the instruction issues
    task automatic check_outputs();
        ckpt_id_t id_2;
        id_2 = exp_id + ckpt_id_t'(kind_1 == KIND_BRANCH);
        check_val("ready_o", int'(ready_o), int'(want[0] != 0 || flush_valid));
        check_val("valid_o_1", int'(valid_o_1), want[0]);
        if (want[0] != 0) begin
            check_val("pdst_1", int'(pdst_1), want[1]);
            check_val("psrc1_1", int'(psrc1_1), want[2]);
            check_val("psrc2_1", int'(psrc2_1), want[3]);
            check_val("ppdst_1", int'(ppdst_1), want[4]);
            check_val("rat_id_1", int'(rat_id_1), int'(exp_id));
        end
        check_val("valid_o_2", int'(valid_o_2), want[5]);
        if (want[5] != 0) begin
            check_val("pdst_2", int'(pdst_2), want[6]);
            check_val("psrc1_2", int'(psrc1_2), want[7]);
            check_val("psrc2_2", int'(psrc2_2), want[8]);
            check_val("ppdst_2", int'(ppdst_2), want[9]);
            check_val("rat_id_2", int'(rat_id_2), int'(id_2));
        end
    endtask

    // Next id after this edge, a flush resumes after the restored slot
    task automatic track_ckpt_id();
        if (flush_valid) begin
            exp_id = flush_rat_id + 1'b1;
        end else if ((want[0] != 0 && kind_1 == KIND_BRANCH) ||
                     (want[5] != 0 && kind_2 == KIND_BRANCH)) begin
            exp_id = exp_id + 1'b1;
        end
    endtask

    initial begin
        int    fd;
        int    n;
        string text;
        line_no          = 0;
        n_checks         = 0;
        n_errors         = 0;
        exp_id           = '0;
        arst_n           = 1'b0;
        commit_valid_2   = 1'b0;
        commit_flushed_2 = 1'b0;
        commit_ldst_2    = '0;
        commit_pdst_2    = '0;
        commit_ppdst_2   = '0;
        load_line("0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0", n);
        fd = $fopen("sim/rename_patterns.txt", "r");
        repeat (4) @(posedge clk);
        #10;
        arst_n = 1'b1;
        if (fd == 0) begin
            n_errors++;
            $display("Could not open the pattern file sim/rename_patterns.txt");
        end else begin
            while (line_no < MAX_LINES && $fgets(text, fd) != 0) begin
                line_no++;
                // Comment and blank lines take no cycle
                if (text.len() > 1 && text[0] != "#") begin
                    @(posedge clk);
                    #10;
                    load_line(text, n);
                    if (n != NCOL) begin
                        n_errors++;
                        $display("Pattern line %0d holds %0d fields instead of %0d",
                            line_no, n, NCOL);
                    end else begin
                        #80;
                        check_outputs();
                        track_ckpt_id();
                    end
                end
            end
            if (line_no >= MAX_LINES) begin
                n_errors++;
                $display("Timed out, the pattern file runs past %0d lines", MAX_LINES);
            end
            $fclose(fd);
        end
        @(posedge clk);
        n_assert = uut.u_ctrl.u_chk.n_fail;
        $display("Checks: %0d, value errors: %0d, assertion failures: %0d",
            n_checks, n_errors, n_assert);
        if (n_errors == 0 && n_assert == 0 && n_checks > 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: sim/rename_chk.sv
module rename_chk (
    input logic                    clk,
    input logic                    arst_n,
    input logic                    valid_i_1,
    input logic                    valid_i_2,
    input rename_pkg::instr_kind_e kind_1,
    input rename_pkg::instr_kind_e kind_2,
    input logic                    flush_valid,
    input logic                    valid_o_1,
    input logic                    valid_o_2,
    input logic [1:0]              pop_cnt,
    input logic                    has_1,
    input logic                    has_2
);
    import rename_pkg::*;

    logic [1:0] avail;
    int         n_fail = 0;

    // Free entries, saturated at two
    assign avail = has_2 ? 2'd2 : {1'b0, has_1};

    pop_in_range: assert property (@(posedge clk) disable iff (!arst_n) pop_cnt <= avail)
    else begin
        $error("pop of %0d with only %0d free", pop_cnt, avail);
        n_fail++;
    end

    quiet_on_flush: assert property (@(posedge clk) disable iff (!arst_n)
        flush_valid |-> !valid_o_1 && !valid_o_2)
    else begin
        $error("valid output high during a flush");
        n_fail++;
    end

    second_needs_first: assert property (@(posedge clk) disable iff (!arst_n)
        valid_o_2 |-> valid_o_1)
    else begin
        $error("valid_o_2 high without valid_o_1");
        n_fail++;
    end

    // Input side, a pair holds at most one branch
    one_branch_per_pair: assert property (@(posedge clk) disable iff (!arst_n)
        !(valid_i_1 && valid_i_2 && kind_1 == KIND_BRANCH && kind_2 == KIND_BRANCH))
    else begin
        $error("pair with two branches");
        n_fail++;
    end

endmodule

// File: verilog/rename_stage.sv
module rename_stage (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    valid_i_1,
    input  rename_pkg::instr_kind_e kind_1,
    input  rename_pkg::lreg_t       rd_1, rs1_1, rs2_1,
    input  logic                    valid_i_2,
    input  rename_pkg::instr_kind_e kind_2,
    input  rename_pkg::lreg_t       rd_2, rs1_2, rs2_2,
    input  logic                    ready_i,
    input  logic                    rob_full,
    input  logic                    rob_two_empty,
    output logic                    valid_o_1,
    output rename_pkg::preg_t       pdst_1, psrc1_1, psrc2_1, ppdst_1,
    output logic                    valid_o_2,
    output rename_pkg::preg_t       pdst_2, psrc1_2, psrc2_2, ppdst_2,
    output rename_pkg::ckpt_id_t    rat_id_1, rat_id_2,
    output logic                    ready_o,
    input  logic                    commit_valid_1, commit_flushed_1,
    input  rename_pkg::lreg_t       commit_ldst_1,
    input  rename_pkg::preg_t       commit_pdst_1, commit_ppdst_1,
    input  logic                    commit_valid_2, commit_flushed_2,
    input  rename_pkg::lreg_t       commit_ldst_2,
    input  rename_pkg::preg_t       commit_pdst_2, commit_ppdst_2,
    input  logic                    flush_valid,
    input  rename_pkg::ckpt_id_t    flush_rat_id
);
    import rename_pkg::*;

    lreg_t    raddr_1s1, raddr_1s2, raddr_2s1, raddr_2s2, raddr_1d, raddr_2d;
    preg_t    rdata_1s1, rdata_1s2, rdata_2s1, rdata_2s2, rdata_1d, rdata_2d;
    ckpt_id_t current_id;
    logic     push_1;
    logic     push_2;
    preg_t    push_data_1;
    preg_t    push_data_2;

    alloc_if  alloc ();
    rat_wr_if wr ();

    // Reclaim, squashed instructions give back their own register
    assign push_1      = commit_valid_1 & (|commit_ldst_1);
    assign push_data_1 = commit_flushed_1 ? commit_pdst_1 : commit_ppdst_1;
    assign push_2      = commit_valid_2 & (|commit_ldst_2);
    assign push_data_2 = commit_flushed_2 ? commit_pdst_2 : commit_ppdst_2;

    free_list u_free_list (
        .clk         (clk),
        .arst_n      (arst_n),
        .push_1      (push_1),
        .push_data_1 (push_data_1),
        .push_2      (push_2),
        .push_data_2 (push_data_2),
        .alloc       (alloc)
    );

    rat u_rat (
        .restore    (flush_valid),
        .restore_id (flush_rat_id),
        .wr         (wr),
        .*
    );

    rename_ctrl u_ctrl (
        .alloc (alloc),
        .wr    (wr),
        .*
    );

endmodule

// File: verilog/rename_ctrl.sv
module rename_ctrl (
    input  logic                    valid_i_1,
    input  rename_pkg::instr_kind_e kind_1,
    input  rename_pkg::lreg_t       rd_1, rs1_1, rs2_1,
    input  logic                    valid_i_2,
    input  rename_pkg::instr_kind_e kind_2,
    input  rename_pkg::lreg_t       rd_2, rs1_2, rs2_2,
    input  logic                    ready_i,
    input  logic                    rob_full,
    input  logic                    rob_two_empty,
    input  logic                    flush_valid,
    output rename_pkg::lreg_t       raddr_1s1, raddr_1s2, raddr_2s1, raddr_2s2,
    output rename_pkg::lreg_t       raddr_1d, raddr_2d,
    input  rename_pkg::preg_t       rdata_1s1, rdata_1s2, rdata_2s1, rdata_2s2,
    input  rename_pkg::preg_t       rdata_1d, rdata_2d,
    output logic                    valid_o_1,
    output rename_pkg::preg_t       pdst_1, psrc1_1, psrc2_1, ppdst_1,
    output logic                    valid_o_2,
    output rename_pkg::preg_t       pdst_2, psrc1_2, psrc2_2, ppdst_2,
    output rename_pkg::ckpt_id_t    rat_id_1, rat_id_2,
    output logic                    ready_o,
    alloc_if.ctrl                   alloc,
    rat_wr_if.ctrl                  wr,
    input  rename_pkg::ckpt_id_t    current_id
);
    import rename_pkg::*;

    logic rn_1;
    logic rn_2;
    logic is_br_1;
    logic is_br_2;
    logic issue_ok;

    // Only ALU and LOAD write a nonzero destination
    assign rn_1 = (|rd_1) & ((kind_1 == KIND_ALU) | (kind_1 == KIND_LOAD));
    assign rn_2 = (|rd_2) & ((kind_2 == KIND_ALU) | (kind_2 == KIND_LOAD));
    assign is_br_1 = kind_1 == KIND_BRANCH;
    assign is_br_2 = kind_2 == KIND_BRANCH;

    assign raddr_1s1 = rs1_1;
    assign raddr_1s2 = rs2_1;
    assign raddr_2s1 = rs1_2;
    assign raddr_2s2 = rs2_2;
    assign raddr_1d  = rd_1;
    assign raddr_2d  = rd_2;

    assign pdst_1  = rn_1 ? alloc.head_1 : preg_t'(rd_1);
    assign psrc1_1 = rdata_1s1;
    assign psrc2_1 = rdata_1s2;
    assign ppdst_1 = rdata_1d;

    // A lone renamer in the pair takes head_1
    assign pdst_2 = !rn_2 ? preg_t'(rd_2) : (rn_1 ? alloc.head_2 : alloc.head_1);

    // RAW inside the pair, store and x0 never match
    assign psrc1_2 = (rn_1 && (rs1_2 == rd_1)) ? pdst_1 : rdata_2s1;
    assign psrc2_2 = (rn_1 && (rs2_2 == rd_1)) ? pdst_1 : rdata_2s2;
    // WAW inside the pair
    assign ppdst_2 = (rn_1 && (rd_2 == rd_1)) ? pdst_1 : rdata_2d;

    assign issue_ok = ready_i & ~rob_full & ~flush_valid;

    always_comb begin
        valid_o_1 = 1'b0;
        valid_o_2 = 1'b0;
        if (valid_i_1 && valid_i_2) begin
            case ({rn_1, rn_2})
                2'b11:   valid_o_1 = issue_ok & rob_two_empty & alloc.has_2;
                2'b00:   valid_o_1 = issue_ok & rob_two_empty;
                default: valid_o_1 = issue_ok & rob_two_empty & alloc.has_1;
            endcase
            valid_o_2 = valid_o_1;
        end else if (valid_i_1) begin
            valid_o_1 = issue_ok & (~rn_1 | alloc.has_1);
        end
    end

    assign alloc.pop_cnt = 2'(valid_o_1 & rn_1) + 2'(valid_o_2 & rn_2);

    // Port 1 carries whichever instruction renames first
    assign wr.we_1      = valid_o_1 & (rn_1 | (valid_o_2 & rn_2));
    assign wr.waddr_1   = rn_1 ? rd_1 : rd_2;
    assign wr.wdata_1   = alloc.head_1;
    assign wr.we_2      = valid_o_2 & rn_1 & rn_2;
    assign wr.waddr_2   = rd_2;
    assign wr.wdata_2   = alloc.head_2;
    assign wr.take_ckpt = (valid_o_1 & is_br_1) | (valid_o_2 & is_br_2);

    assign rat_id_1 = current_id;
    assign rat_id_2 = is_br_1 ? current_id + 1'b1 : current_id;

    assign ready_o = valid_o_1 | flush_valid;

endmodule

// File: verilog/rat.sv
`include "rename_settings.svh"

module rat (
    input  logic                 clk,
    input  logic                 arst_n,
    input  rename_pkg::lreg_t    raddr_1s1, raddr_1s2, raddr_2s1, raddr_2s2,
    input  rename_pkg::lreg_t    raddr_1d, raddr_2d,
    output rename_pkg::preg_t    rdata_1s1, rdata_1s2, rdata_2s1, rdata_2s2,
    output rename_pkg::preg_t    rdata_1d, rdata_2d,
    rat_wr_if.rat                wr,
    output rename_pkg::ckpt_id_t current_id,
    input  logic                 restore,
    input  rename_pkg::ckpt_id_t restore_id
);
    import rename_pkg::*;

    preg_t [`NUM_LREG-1:0] map_q;
    preg_t [`NUM_LREG-1:0] map_next;
    preg_t [`NUM_LREG-1:0] ckpt_q [`NUM_CKPT];

    assign rdata_1s1 = map_q[raddr_1s1];
    assign rdata_1s2 = map_q[raddr_1s2];
    assign rdata_2s1 = map_q[raddr_2s1];
    assign rdata_2s2 = map_q[raddr_2s2];
    assign rdata_1d  = map_q[raddr_1d];
    assign rdata_2d  = map_q[raddr_2d];

    always_comb begin
        map_next = map_q;
        if (wr.we_1) begin
            map_next[wr.waddr_1] = wr.wdata_1;
        end
        // Younger instruction wins a same-register WAW
        if (wr.we_2) begin
            map_next[wr.waddr_2] = wr.wdata_2;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // Identity map, xN lives in pN
            for (int i = 0; i < `NUM_LREG; i++) begin
                map_q[i] <= preg_t'(i);
            end
            current_id <= '0;
        end else if (restore) begin
            map_q      <= ckpt_q[restore_id];
            current_id <= restore_id + 1'b1;
        end else begin
            map_q <= map_next;
            if (wr.take_ckpt) begin
                current_id <= current_id + 1'b1;
            end
        end
    end

    // Snapshot includes the writes of the branch cycle
    always_ff @(posedge clk) begin
        if (wr.take_ckpt && !restore) begin
            ckpt_q[current_id] <= map_next;
        end
    end

endmodule

// File: verilog/free_list.sv
`include "rename_settings.svh"

module free_list (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              push_1,
    input  rename_pkg::preg_t push_data_1,
    input  logic              push_2,
    input  rename_pkg::preg_t push_data_2,
    alloc_if.fl               alloc
);
    import rename_pkg::*;

    localparam int PTR_W = $clog2(`FL_DEPTH);
    localparam int CNT_W = $clog2(`FL_DEPTH + 1);

    preg_t            fifo_q [`FL_DEPTH];
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] head_nxt;
    logic [PTR_W-1:0] tail_q;
    logic [PTR_W-1:0] tail_2;
    logic [CNT_W-1:0] count_q;

    // Depth is a power of two, pointers wrap by themselves
    assign head_nxt = head_q + 1'b1;
    assign tail_2   = push_1 ? tail_q + 1'b1 : tail_q;

    assign alloc.head_1 = fifo_q[head_q];
    assign alloc.head_2 = fifo_q[head_nxt];
    assign alloc.has_1  = count_q != '0;
    assign alloc.has_2  = count_q >= CNT_W'(2);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // Everything above the architectural set starts free
            for (int i = 0; i < `FL_DEPTH; i++) begin
                fifo_q[i] <= preg_t'(`NUM_PREG - `FL_DEPTH + i);
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= CNT_W'(`FL_DEPTH);
        end else begin
            if (push_1) begin
                fifo_q[tail_q] <= push_data_1;
            end
            if (push_2) begin
                fifo_q[tail_2] <= push_data_2;
            end
            head_q  <= head_q + PTR_W'(alloc.pop_cnt);
            tail_q  <= tail_q + PTR_W'(push_1) + PTR_W'(push_2);
            count_q <= count_q - CNT_W'(alloc.pop_cnt) + CNT_W'(push_1) + CNT_W'(push_2);
        end
    end

endmodule

// File: verilog/rename_ifs.sv
interface alloc_if;
    import rename_pkg::*;

    preg_t      head_1;
    preg_t      head_2;
    logic       has_1;
    logic       has_2;
    // Registers taken at the edge, 0 to 2
    logic [1:0] pop_cnt;

    modport fl (
        output head_1, head_2, has_1, has_2,
        input  pop_cnt
    );

    modport ctrl (
        input  head_1, head_2, has_1, has_2,
        output pop_cnt
    );

endinterface

interface rat_wr_if;
    import rename_pkg::*;

    logic  we_1;
    lreg_t waddr_1;
    preg_t wdata_1;
    logic  we_2;
    lreg_t waddr_2;
    preg_t wdata_2;
    logic  take_ckpt;

    modport rat (
        input we_1, waddr_1, wdata_1, we_2, waddr_2, wdata_2, take_ckpt
    );

    modport ctrl (
        output we_1, waddr_1, wdata_1, we_2, waddr_2, wdata_2, take_ckpt
    );

endinterface

// File: verilog/rename_pkg.sv
`include "rename_settings.svh"

package rename_pkg;

    typedef logic [`LREG_W-1:0] lreg_t;
    typedef logic [`PREG_W-1:0] preg_t;

    // One bit, matches the two RAT snapshots
    typedef logic ckpt_id_t;

    // Replaces the functional unit and micro-op codes
    typedef enum logic [1:0] {
        KIND_ALU    = 2'd0,
        KIND_LOAD   = 2'd1,
        KIND_STORE  = 2'd2,
        KIND_BRANCH = 2'd3
    } instr_kind_e;

endpackage

// File: verilog/rename_settings.svh
`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

// Register index widths
`define LREG_W   5
`define PREG_W   6

`define NUM_LREG 32
`define NUM_PREG 64

// Free list capacity and RAT snapshots
`define FL_DEPTH 32
`define NUM_CKPT 2

`endif
